/* rtl/tage_bank.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_bank (
    input  logic                          clk,
    input  logic                          rst,
    input  tage_pred_pkg::tage_index_t    index,
    input  tage_pred_pkg::tage_tag_t      tag,
    output logic                          hit,
    output tage_pred_pkg::tage_ctr_t      ctr,
    output tage_pred_pkg::tage_useful_t   useful,
    input  tage_upd_pkg::tage_bank_upd_t  upd,
    input  logic                          refresh_hi,
    input  logic                          refresh_lo
);
    import tage_pred_pkg::*;
    import tage_upd_pkg::*;

    localparam int ENTRIES = 1 << `TAGE_INDEX_BITS;

    logic         valid_q  [ENTRIES];
    tage_tag_t    tag_q    [ENTRIES];
    tage_ctr_t    ctr_q    [ENTRIES];
    tage_useful_t useful_q [ENTRIES];

    tage_ctr_t    ctr_old;
    tage_useful_t useful_old;

    // Read port
    assign hit = valid_q[index] && (tag_q[index] == tag);
    assign ctr = ctr_q[index];
    assign useful = useful_q[index];

    assign ctr_old = ctr_q[upd.index];
    assign useful_old = useful_q[upd.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                tag_q[i] <= '0;
                ctr_q[i] <= 3'd3;
                useful_q[i] <= '0;
            end
        end else begin
            // Graceful aging, one useful bit per pulse
            for (int i = 0; i < ENTRIES; i++) begin
                if (refresh_hi) useful_q[i][1] <= 1'b0;
                if (refresh_lo) useful_q[i][0] <= 1'b0;
            end

            if (upd.we) begin
                if (upd.tag_write) begin
                    valid_q[upd.index] <= 1'b1;
                    tag_q[upd.index] <= upd.tag;
                    ctr_q[upd.index] <= upd.ctr;
                    useful_q[upd.index] <= upd.useful;
                end else begin
                    // Saturating steps on the stored entry
                    if (upd.ctr == CTR_STEP_UP && ctr_old != 3'd7) begin
                        ctr_q[upd.index] <= ctr_old + 3'd1;
                    end else if (upd.ctr == CTR_STEP_DOWN && ctr_old != 3'd0) begin
                        ctr_q[upd.index] <= ctr_old - 3'd1;
                    end
                    if (upd.useful == USEFUL_STEP_UP && useful_old != 2'd3) begin
                        useful_q[upd.index] <= useful_old + 2'd1;
                    end else if (upd.useful == USEFUL_STEP_DOWN && useful_old != 2'd0) begin
                        useful_q[upd.index] <= useful_old - 2'd1;
                    end
                end
            end
        end
    end

endmodule

/* rtl/tage_base.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_base (
    input  logic                         clk,
    input  logic                         rst,
    input  tage_pred_pkg::tage_index_t   index,
    output logic [1:0]                   ctr,
    input  tage_upd_pkg::tage_base_upd_t upd
);

    localparam int ENTRIES = 1 << `TAGE_INDEX_BITS;

    // Bimodal counters, msb is the direction
    logic [1:0] ctr_q [ENTRIES];

    assign ctr = ctr_q[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Weakly not taken
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else if (upd.we) begin
            ctr_q[upd.index] <= upd.ctr;
        end
    end

endmodule

/* rtl/tage_cfg.svh */
`ifndef TAGE_CFG_SVH
`define TAGE_CFG_SVH

// Table geometry
`define TAGE_INDEX_BITS 10
`define TAGE_TAG_BITS 8
`define TAGE_NUM_BANKS 4

// Global history length per tagged bank, shortest first
`define TAGE_HIST_LEN_0 10
`define TAGE_HIST_LEN_1 20
`define TAGE_HIST_LEN_2 40
`define TAGE_HIST_LEN_3 80

// Accepted commits between two useful-bit refresh pulses
`define TAGE_REFRESH_PERIOD 64

`endif

/* rtl/tage_history.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_history (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pause,
    input  logic                      recover,
    input  logic                      branch_happen,
    input  logic                      pred_taken,
    input  logic [31:0]               br_pc,
    input  logic                      commit,
    input  logic                      committed_taken,
    output tage_pred_pkg::tage_fold_t fold
);
    import tage_pred_pkg::*;

    localparam int HIST_BITS = `TAGE_HIST_LEN_3;
    localparam int NB = `TAGE_NUM_BANKS;
    localparam int HIST_LEN [NB] = '{`TAGE_HIST_LEN_0, `TAGE_HIST_LEN_1,
                                     `TAGE_HIST_LEN_2, `TAGE_HIST_LEN_3};

    logic [HIST_BITS-1:0] spec_hist;
    logic [HIST_BITS-1:0] com_hist;
    logic [HIST_BITS-1:0] com_hist_next;

    // Xor the newest len bits down to index width
    function automatic tage_index_t fold_index(input logic [HIST_BITS-1:0] h, input int len);
        tage_index_t f;
        f = '0;
        for (int j = 0; j < HIST_BITS; j++) begin
            if (j < len) f[j % `TAGE_INDEX_BITS] ^= h[j];
        end
        return f;
    endfunction

    // Same, down to tag width
    function automatic tage_tag_t fold_tag(input logic [HIST_BITS-1:0] h, input int len);
        tage_tag_t f;
        f = '0;
        for (int j = 0; j < HIST_BITS; j++) begin
            if (j < len) f[j % `TAGE_TAG_BITS] ^= h[j];
        end
        return f;
    endfunction

    assign com_hist_next = commit ? {com_hist[HIST_BITS-2:0], committed_taken} : com_hist;

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_hist <= '0;
            com_hist <= '0;
        end else begin
            com_hist <= com_hist_next;
            // Recover wins over a new speculative branch
            if (recover) begin
                spec_hist <= com_hist_next;
            end else if (branch_happen && !pause) begin
                spec_hist <= {spec_hist[HIST_BITS-2:0], pred_taken};
            end
        end
    end

    always_comb begin
        fold.base_index = br_pc[13:4];
        for (int b = 0; b < NB; b++) begin
            fold.bank_index[b] = fold_index(spec_hist, HIST_LEN[b]) ^ br_pc[13:4];
            fold.bank_tag[b] = br_pc[21:14] ^ fold_tag(spec_hist, HIST_LEN[b]);
        end
    end

endmodule

/* rtl/tage_pred_pkg.sv */
`include "tage_cfg.svh"

package tage_pred_pkg;

    typedef logic [`TAGE_INDEX_BITS-1:0] tage_index_t;
    typedef logic [`TAGE_TAG_BITS-1:0] tage_tag_t;

    // 3-bit prediction counter, msb set means taken
    typedef logic [2:0] tage_ctr_t;
    typedef logic [1:0] tage_useful_t;

    // Everything derived from pc and history at prediction time
    typedef struct packed {
        tage_index_t base_index;
        tage_index_t [`TAGE_NUM_BANKS-1:0] bank_index;
        tage_tag_t [`TAGE_NUM_BANKS-1:0] bank_tag;
    } tage_fold_t;

    // Travels with the branch down the pipe and comes back at commit.
    // With no provider, provider_ctr holds the base counter in its low two bits
    typedef struct packed {
        logic provider_hit;
        logic [1:0] provider_bank;
        tage_ctr_t provider_ctr;
        logic alt_taken;
        logic [`TAGE_NUM_BANKS-1:0] useful_zero;
        tage_fold_t fold;
    } tage_pred_info_t;

endpackage

/* rtl/tage_predictor.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_predictor (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pause,
    input  logic                           recover,
    input  logic                           branch_happen,
    input  logic [31:0]                    br_pc,
    output logic                           pred_taken,
    output tage_pred_pkg::tage_pred_info_t pred_info,
    input  logic                           commit,
    input  tage_pred_pkg::tage_pred_info_t committed_pred_info,
    input  logic                           committed_taken
);
    import tage_pred_pkg::*;
    import tage_upd_pkg::*;

    localparam int NB = `TAGE_NUM_BANKS;

    tage_fold_t                fold;
    logic [1:0]                base_ctr;
    logic [NB-1:0]             hit;
    tage_ctr_t [NB-1:0]        ctr;
    tage_useful_t [NB-1:0]     useful;
    tage_bank_upd_t [NB-1:0]   bank_upd;
    tage_base_upd_t            base_upd;
    logic                      commit_taken_pulse;
    logic                      refresh_hi;
    logic                      refresh_lo;

    tage_history history_i (
        .clk, .rst, .pause, .recover, .branch_happen, .pred_taken,
        .br_pc, .commit, .committed_taken, .fold
    );

    tage_base base_i (
        .clk, .rst, .index(fold.base_index), .ctr(base_ctr), .upd(base_upd)
    );

    for (genvar b = 0; b < NB; b++) begin : g_bank
        tage_bank bank_i (
            .clk, .rst,
            .index(fold.bank_index[b]),
            .tag(fold.bank_tag[b]),
            .hit(hit[b]),
            .ctr(ctr[b]),
            .useful(useful[b]),
            .upd(bank_upd[b]),
            .refresh_hi, .refresh_lo
        );
    end

    tage_update_fsm update_fsm_i (
        .clk, .rst, .commit, .committed_taken, .committed_pred_info,
        .bank_upd, .base_upd, .commit_taken_pulse
    );

    tage_refresh_timer refresh_timer_i (
        .clk, .rst, .commit_taken_pulse, .refresh_hi, .refresh_lo
    );

    ////////////////////////////////////////////////////////////////////////////
    // Provider and alternate
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        pred_info = '0;
        pred_info.fold = fold;
        pred_info.provider_ctr = {1'b0, base_ctr};
        pred_info.alt_taken = base_ctr[1];
        // Walk upward so the longest hit ends as provider
        for (int b = 0; b < NB; b++) begin
            pred_info.useful_zero[b] = (useful[b] == '0);
            if (hit[b]) begin
                pred_info.alt_taken = pred_info.provider_hit ?
                                      pred_info.provider_ctr[2] : base_ctr[1];
                pred_info.provider_hit = 1'b1;
                pred_info.provider_bank = b[1:0];
                pred_info.provider_ctr = ctr[b];
            end
        end
    end

    assign pred_taken = pred_info.provider_hit ? pred_info.provider_ctr[2] : base_ctr[1];

endmodule

/* rtl/tage_refresh_timer.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_refresh_timer (
    input  logic clk,
    input  logic rst,
    input  logic commit_taken_pulse,
    output logic refresh_hi,
    output logic refresh_lo
);

    localparam int CNT_BITS = $clog2(`TAGE_REFRESH_PERIOD);

    logic [CNT_BITS-1:0] count;
    // Low means the next pulse clears the high useful bit
    logic                phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            phase <= 1'b0;
            refresh_hi <= 1'b0;
            refresh_lo <= 1'b0;
        end else begin
            refresh_hi <= 1'b0;
            refresh_lo <= 1'b0;
            if (commit_taken_pulse) begin
                if (count == CNT_BITS'(`TAGE_REFRESH_PERIOD - 1)) begin
                    count <= '0;
                    phase <= ~phase;
                    refresh_hi <= ~phase;
                    refresh_lo <= phase;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/tage_upd_pkg.sv */
`include "tage_cfg.svh"

package tage_upd_pkg;

    // tag_write set: ctr, useful and tag are stored as given and valid is set.
    // tag_write clear: ctr and useful are signed steps, saturated in the bank
    typedef struct packed {
        logic we;
        tage_pred_pkg::tage_index_t index;
        tage_pred_pkg::tage_tag_t tag;
        tage_pred_pkg::tage_ctr_t ctr;
        tage_pred_pkg::tage_useful_t useful;
        logic tag_write;
    } tage_bank_upd_t;

    typedef struct packed {
        logic we;
        tage_pred_pkg::tage_index_t index;
        logic [1:0] ctr;
    } tage_base_upd_t;

    // Step codes used when tag_write is clear
    parameter tage_pred_pkg::tage_ctr_t CTR_STEP_UP = 3'b001;
    parameter tage_pred_pkg::tage_ctr_t CTR_STEP_DOWN = 3'b111;
    parameter tage_pred_pkg::tage_useful_t USEFUL_STEP_UP = 2'b01;
    parameter tage_pred_pkg::tage_useful_t USEFUL_STEP_DOWN = 2'b11;

endpackage

/* rtl/tage_update_fsm.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_update_fsm (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               commit,
    input  logic                                               committed_taken,
    input  tage_pred_pkg::tage_pred_info_t                     committed_pred_info,
    output tage_upd_pkg::tage_bank_upd_t [`TAGE_NUM_BANKS-1:0] bank_upd,
    output tage_upd_pkg::tage_base_upd_t                       base_upd,
    output logic                                               commit_taken_pulse
);
    import tage_pred_pkg::*;
    import tage_upd_pkg::*;

    localparam int NB = `TAGE_NUM_BANKS;

    typedef enum logic {IDLE, WRITE} state_t;

    state_t          state;
    tage_pred_info_t info_q;
    logic            taken_q;

    logic            pred_dir;
    logic            mispredict;
    logic [NB-1:0]   longer;
    logic [NB-1:0]   free;
    logic            alloc_found;
    logic [1:0]      alloc_bank;

    ////////////////////////////////////////////////////////////////////////////
    // Capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (commit) state <= WRITE;
                default: state <= IDLE;
            endcase
        end
    end

    // A commit seen in WRITE is lost
    always_ff @(posedge clk) begin
        if (state == IDLE && commit) begin
            info_q <= committed_pred_info;
            taken_q <= committed_taken;
        end
    end

    assign commit_taken_pulse = (state == WRITE);

    ////////////////////////////////////////////////////////////////////////////
    // Table writes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        bank_upd = '0;
        base_upd = '0;

        pred_dir = info_q.provider_hit ? info_q.provider_ctr[2] : info_q.provider_ctr[1];
        mispredict = (pred_dir != taken_q);

        // Banks with longer history than the provider
        for (int b = 0; b < NB; b++) begin
            longer[b] = !info_q.provider_hit || (b > int'(info_q.provider_bank));
        end
        free = longer & info_q.useful_zero;

        // Lowest free bank wins
        alloc_found = 1'b0;
        alloc_bank = '0;
        for (int b = NB - 1; b >= 0; b--) begin
            if (free[b]) begin
                alloc_found = 1'b1;
                alloc_bank = b[1:0];
            end
        end

        for (int b = 0; b < NB; b++) begin
            bank_upd[b].index = info_q.fold.bank_index[b];
            bank_upd[b].tag = info_q.fold.bank_tag[b];
        end
        base_upd.index = info_q.fold.base_index;

        if (state == WRITE) begin
            if (info_q.provider_hit) begin
                bank_upd[info_q.provider_bank].we = 1'b1;
                bank_upd[info_q.provider_bank].ctr = taken_q ? CTR_STEP_UP : CTR_STEP_DOWN;
                // Useful moves only when the alternate disagreed
                if (info_q.alt_taken != pred_dir) begin
                    bank_upd[info_q.provider_bank].useful =
                        mispredict ? USEFUL_STEP_DOWN : USEFUL_STEP_UP;
                end
            end else begin
                base_upd.we = 1'b1;
                if (taken_q) begin
                    base_upd.ctr = (info_q.provider_ctr[1:0] == 2'd3) ?
                                   2'd3 : info_q.provider_ctr[1:0] + 2'd1;
                end else begin
                    base_upd.ctr = (info_q.provider_ctr[1:0] == 2'd0) ?
                                   2'd0 : info_q.provider_ctr[1:0] - 2'd1;
                end
            end

            if (mispredict && longer != '0) begin
                if (alloc_found) begin
                    bank_upd[alloc_bank].we = 1'b1;
                    bank_upd[alloc_bank].tag_write = 1'b1;
                    bank_upd[alloc_bank].ctr = taken_q ? 3'd4 : 3'd3;
                    bank_upd[alloc_bank].useful = '0;
                end else begin
                    // Nothing free, age every candidate
                    for (int b = 0; b < NB; b++) begin
                        if (longer[b]) begin
                            bank_upd[b].we = 1'b1;
                            bank_upd[b].useful = USEFUL_STEP_DOWN;
                        end
                    end
                end
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the TAGE predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tage_tb -o tage_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tage_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

/* sim.f */
+incdir+rtl
rtl/tage_pred_pkg.sv
rtl/tage_upd_pkg.sv
rtl/tage_history.sv
rtl/tage_bank.sv
rtl/tage_base.sv
rtl/tage_update_fsm.sv
rtl/tage_refresh_timer.sv
rtl/tage_predictor.sv
testbench/tage_tb.sv

/* testbench/tage_tb.sv */
`timescale 1ns/1ps
`include "tage_cfg.svh"

module tage_tb;
    import tage_pred_pkg::*;

    localparam int NUM_ROWS = 21;
    localparam int FILLERS = 2 * `TAGE_REFRESH_PERIOD;
    localparam int RESET_CYCLES = 16;
    localparam int HIST_BITS = `TAGE_HIST_LEN_3;
    localparam longint TIMEOUT_NS = 10 * (NUM_ROWS * 8 + FILLERS * 8 + RESET_CYCLES);

    // Branch addresses used by the table
    localparam logic [31:0] PC_A = 32'h0000_1230;  // base index 0x123, tag bits 0
    localparam logic [31:0] PC_B = 32'h0000_5230;  // same base index, tag bits 1
    localparam logic [31:0] PC_C = 32'h0000_9230;  // same base index, tag bits 2
    localparam logic [31:0] PC_D = 32'h0005_5370;  // lands on 0x123 under history 0x14

    typedef enum logic [2:0] {
        OP_PREDICT, OP_COMMIT, OP_PAUSE, OP_SHIFT, OP_RECOVER, OP_BURST
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] pc;
        logic        outcome;
        logic        exp_taken;
        logic        exp_hit;
        logic [1:0]  exp_bank;
        logic [1:0]  idx_bank;
        logic [3:0]  exp_mask;
    } row_t;

    logic            clk;
    logic            rst;
    logic            pause;
    logic            recover;
    logic            branch_happen;
    logic [31:0]     br_pc;
    logic            pred_taken;
    tage_pred_info_t pred_info;
    logic            commit;
    tage_pred_info_t committed_pred_info;
    logic            committed_taken;

    row_t                 rows [NUM_ROWS];
    logic [HIST_BITS-1:0] spec_model;
    logic [HIST_BITS-1:0] com_model;
    int                   errors;
    int                   checks;

    tage_predictor dut_i (
        .clk, .rst, .pause, .recover, .branch_happen, .br_pc, .pred_taken,
        .pred_info, .commit, .committed_pred_info, .committed_taken
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of the index rule
    ////////////////////////////////////////////////////////////////////////////

    function automatic int hist_len(input int bank);
        case (bank)
            0:       return `TAGE_HIST_LEN_0;
            1:       return `TAGE_HIST_LEN_1;
            2:       return `TAGE_HIST_LEN_2;
            default: return `TAGE_HIST_LEN_3;
        endcase
    endfunction

    // pc[13:4] xor each 10-bit slice of the newest history bits
    function automatic tage_index_t model_index(input logic [HIST_BITS-1:0] hist,
                                                input int bank, input logic [31:0] pc);
        tage_index_t idx;
        idx = pc[13:4];
        for (int k = 0; k < hist_len(bank) / `TAGE_INDEX_BITS; k++) begin
            idx ^= hist[k*`TAGE_INDEX_BITS +: `TAGE_INDEX_BITS];
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_prediction(input row_t r, input int n);
        check_value($sformatf("pred_taken (row %0d)", n), pred_taken, r.exp_taken);
        check_value($sformatf("provider_hit (row %0d)", n), pred_info.provider_hit, r.exp_hit);
        if (r.exp_hit) begin
            check_value($sformatf("provider_bank (row %0d)", n),
                        pred_info.provider_bank, r.exp_bank);
        end
        check_value($sformatf("useful_zero (row %0d)", n), pred_info.useful_zero, r.exp_mask);
        check_value($sformatf("bank_index[%0d] (row %0d)", r.idx_bank, n),
                    pred_info.fold.bank_index[r.idx_bank],
                    model_index(spec_model, r.idx_bank, r.pc));
    endtask

    // One strobe, then an idle cycle so the FSM is back in IDLE
    task automatic send_commit(input tage_pred_info_t info, input logic taken);
        commit = 1'b1;
        committed_pred_info = info;
        committed_taken = taken;
        com_model = {com_model[HIST_BITS-2:0], taken};
        @(negedge clk);
        commit = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_burst();
        tage_pred_info_t seen;
        logic [31:0]     rnd;
        for (int i = 0; i < FILLERS; i++) begin
            @(negedge clk);
            // pc bit 13 keeps filler entries away from index 0x123 and 0x137
            br_pc = $urandom() | 32'h0000_2000;
            #2;
            seen = pred_info;
            rnd = $urandom();
            @(negedge clk);
            send_commit(seen, rnd[0]);
        end
    endtask

    task automatic apply_row(input row_t r, input int n);
        tage_pred_info_t seen;
        if (r.op == OP_BURST) begin
            run_burst();
        end else begin
            @(negedge clk);
            br_pc = r.pc;
            pause = (r.op == OP_PAUSE);
            branch_happen = (r.op == OP_PAUSE) || (r.op == OP_SHIFT);
            recover = (r.op == OP_RECOVER);
            #2;
            check_prediction(r, n);
            seen = pred_info;
            @(negedge clk);
            pause = 1'b0;
            branch_happen = 1'b0;
            recover = 1'b0;
            case (r.op)
                OP_SHIFT:   spec_model = {spec_model[HIST_BITS-2:0], r.exp_taken};
                OP_RECOVER: spec_model = com_model;
                OP_COMMIT:  send_commit(seen, r.outcome);
                default:    ;
            endcase
        end
    endtask

    task automatic fill_table();
        // op, pc, outcome, taken, hit, bank, index bank, useful_zero
        rows[0]  = '{OP_PREDICT, PC_A, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[1]  = '{OP_COMMIT,  PC_A, 1'b1, 1'b0, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[2]  = '{OP_PREDICT, PC_A, 1'b0, 1'b1, 1'b1, 2'd0, 2'd0, 4'hf};
        rows[3]  = '{OP_COMMIT,  PC_A, 1'b0, 1'b1, 1'b1, 2'd0, 2'd0, 4'hf};
        rows[4]  = '{OP_PREDICT, PC_A, 1'b0, 1'b0, 1'b1, 2'd1, 2'd1, 4'hf};
        // Build a useful bank 0 entry for pc B under zero history
        rows[5]  = '{OP_COMMIT,  PC_B, 1'b1, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[6]  = '{OP_COMMIT,  PC_B, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[7]  = '{OP_COMMIT,  PC_B, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'hf};
        rows[8]  = '{OP_PREDICT, PC_B, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'he};
        // Paused branch predicted taken, so a wrong shift would move the index
        rows[9]  = '{OP_PAUSE,   PC_C, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'he};
        rows[10] = '{OP_PREDICT, PC_B, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'he};
        // Speculative shifts, then back to the committed history 0x14
        rows[11] = '{OP_SHIFT,   PC_C, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'he};
        rows[12] = '{OP_PREDICT, PC_A, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[13] = '{OP_SHIFT,   PC_C, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[14] = '{OP_SHIFT,   PC_C, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[15] = '{OP_RECOVER, PC_A, 1'b0, 1'b1, 1'b0, 2'd0, 2'd0, 4'hf};
        rows[16] = '{OP_PREDICT, PC_A, 1'b0, 1'b1, 1'b0, 2'd0, 2'd3, 4'hf};
        rows[17] = '{OP_PREDICT, PC_A, 1'b0, 1'b1, 1'b0, 2'd0, 2'd1, 4'hf};
        // Useful entry seen again through pc D, before and after the refresh pulses
        rows[18] = '{OP_PREDICT, PC_D, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'he};
        rows[19] = '{OP_BURST,   '0,   1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 4'h0};
        rows[20] = '{OP_PREDICT, PC_D, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'hf};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        pause = 1'b0;
        recover = 1'b0;
        branch_happen = 1'b0;
        br_pc = '0;
        commit = 1'b0;
        committed_pred_info = '0;
        committed_taken = 1'b0;
        errors = 0;
        checks = 0;
        spec_model = '0;
        com_model = '0;
        void'($urandom(32'hb517));
        fill_table();

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < NUM_ROWS; n++) begin
            apply_row(rows[n], n);
        end

        @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the stimulus table did not finish within %0d ns", TIMEOUT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
